//--- Makefile
# Verilator build and run for the coleco pad testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_coleco_pad
FILELIST  := all.f
BUILD_DIR := obj_dir
PASS_MSG  := >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
src/coleco_pad_pkg.sv
src/ps2_keypad_emu.sv
src/joy_keypad_map.sv
src/pad_port_encoder.sv
src/coleco_pad_top.sv
testbench/tb_coleco_pad.sv

//--- src/coleco_pad_pkg.sv
//==============================
// coleco pad package
// keypad vector layout, console key codes, joystick bit positions
// and PS/2 scan codes shared by the controller input path
//==============================

package coleco_pad_pkg;

        //==============================
        // keypad vector
        //==============================
        localparam int KEYPAD_W = 20;

        typedef logic [KEYPAD_W-1:0] keypad_t;

        localparam int KP_DIGIT0 = 0;
        localparam int KP_DIGIT1 = 1;
        localparam int KP_DIGIT2 = 2;
        localparam int KP_DIGIT3 = 3;
        localparam int KP_DIGIT4 = 4;
        localparam int KP_DIGIT5 = 5;
        localparam int KP_DIGIT6 = 6;
        localparam int KP_DIGIT7 = 7;
        localparam int KP_DIGIT8 = 8;
        localparam int KP_DIGIT9 = 9;
        localparam int KP_STAR   = 10;
        localparam int KP_HASH   = 11;
        localparam int KP_PURPLE = 12;
        localparam int KP_BLUE   = 13;
        localparam int KP_UP     = 14;
        localparam int KP_DOWN   = 15;
        localparam int KP_LEFT   = 16;
        localparam int KP_RIGHT  = 17;
        localparam int KP_FIRE1  = 18;
        localparam int KP_FIRE2  = 19;

        // entries 0..13 take part in the key code priority scan
        localparam int KP_KEYS = 14;

        //==============================
        // joystick word
        //==============================
        localparam int JOY_W = 32;

        // source joystick bit for every keypad index, in keypad order
        // bits 20 and up of the joystick word are never referenced
        localparam int joy_src_table [0:KEYPAD_W-1] = '{
                8, 9, 10, 11, 12, 13, 14, 15, 16, 17,
                6, 7,
                18, 19,
                3, 2, 1, 0,
                4, 5
        };

        //==============================
        // console key codes
        //==============================
        typedef logic [3:0] key_code_t;

        localparam key_code_t KEY_0      = 4'b0011;
        localparam key_code_t KEY_1      = 4'b1110;
        localparam key_code_t KEY_2      = 4'b1101;
        localparam key_code_t KEY_3      = 4'b0110;
        localparam key_code_t KEY_4      = 4'b0001;
        localparam key_code_t KEY_5      = 4'b1001;
        localparam key_code_t KEY_6      = 4'b0111;
        localparam key_code_t KEY_7      = 4'b1100;
        localparam key_code_t KEY_8      = 4'b1000;
        localparam key_code_t KEY_9      = 4'b1011;
        localparam key_code_t KEY_STAR   = 4'b1010;
        localparam key_code_t KEY_HASH   = 4'b0101;
        localparam key_code_t KEY_PURPLE = 4'b0100;
        localparam key_code_t KEY_BLUE   = 4'b0010;
        // all lines released
        localparam key_code_t KEY_NONE   = 4'b1111;

        localparam key_code_t key_code_table [0:KP_KEYS-1] = '{
                KEY_0, KEY_1, KEY_2, KEY_3, KEY_4,
                KEY_5, KEY_6, KEY_7, KEY_8, KEY_9,
                KEY_STAR, KEY_HASH, KEY_PURPLE, KEY_BLUE
        };

        //==============================
        // PS/2 keyboard event
        //==============================
        // bit 10 toggle, bit 9 pressed, bits 8..0 scan code
        localparam int PS2_W = 11;

        // main row digits
        localparam logic [7:0] SC_1 = 8'h16;
        localparam logic [7:0] SC_2 = 8'h1E;
        localparam logic [7:0] SC_3 = 8'h26;
        localparam logic [7:0] SC_4 = 8'h25;
        localparam logic [7:0] SC_5 = 8'h2E;
        localparam logic [7:0] SC_6 = 8'h36;
        localparam logic [7:0] SC_7 = 8'h3D;
        localparam logic [7:0] SC_8 = 8'h3E;
        localparam logic [7:0] SC_9 = 8'h46;
        localparam logic [7:0] SC_0 = 8'h45;

        // numeric pad digits
        localparam logic [7:0] SCK_1 = 8'h69;
        localparam logic [7:0] SCK_2 = 8'h72;
        localparam logic [7:0] SCK_3 = 8'h7A;
        localparam logic [7:0] SCK_4 = 8'h6B;
        localparam logic [7:0] SCK_5 = 8'h73;
        localparam logic [7:0] SCK_6 = 8'h74;
        localparam logic [7:0] SCK_7 = 8'h6C;
        localparam logic [7:0] SCK_8 = 8'h75;
        localparam logic [7:0] SCK_9 = 8'h7D;
        localparam logic [7:0] SCK_0 = 8'h70;

        localparam logic [7:0] SC_STAR   = 8'h7C;
        localparam logic [7:0] SC_LSHIFT = 8'h12;
        localparam logic [7:0] SC_RSHIFT = 8'h59;
        localparam logic [7:0] SC_MINUS  = 8'h7B;

endpackage

//--- src/coleco_pad_top.sv
//==============================
// coleco pad top level
// keyboard keypad emulation, joystick mapping and the two
// player port encoders
//==============================

`timescale 1ns/1ps

module coleco_pad_top (
        input  logic                             clk_sys,
        input  logic                             rst_n_i,
        input  logic [coleco_pad_pkg::PS2_W-1:0] ps2_key_i,
        input  logic [coleco_pad_pkg::JOY_W-1:0] joy0_i,
        input  logic [coleco_pad_pkg::JOY_W-1:0] joy1_i,
        input  logic                             swap_i,
        input  logic [1:0]                       kp_sel_n_i,
        input  logic [1:0]                       joy_sel_n_i,
        output logic [7:0]                       pad_lines_o,
        output logic [1:0]                       pad_fire_o
);

        coleco_pad_pkg::keypad_t kbd_keypad;
        coleco_pad_pkg::keypad_t keypad_p0;
        coleco_pad_pkg::keypad_t keypad_p1;

        //==============================
        // keyboard and joystick inputs
        //==============================
        ps2_keypad_emu u_kbd (
                .clk_sys      (clk_sys),
                .rst_n_i      (rst_n_i),
                .ps2_key_i    (ps2_key_i),
                .kbd_keypad_o (kbd_keypad)
        );

        joy_keypad_map u_map (
                .joy0_i       (joy0_i),
                .joy1_i       (joy1_i),
                .swap_i       (swap_i),
                .kbd_keypad_i (kbd_keypad),
                .keypad_p0_o  (keypad_p0),
                .keypad_p1_o  (keypad_p1)
        );

        //==============================
        // port encoders
        //==============================
        // player 0 on the low nibble
        pad_port_encoder u_enc0 (
                .clk_sys     (clk_sys),
                .rst_n_i     (rst_n_i),
                .keypad_i    (keypad_p0),
                .kp_sel_n_i  (kp_sel_n_i[0]),
                .joy_sel_n_i (joy_sel_n_i[0]),
                .lines_o     (pad_lines_o[3:0]),
                .fire_o      (pad_fire_o[0])
        );

        pad_port_encoder u_enc1 (
                .clk_sys     (clk_sys),
                .rst_n_i     (rst_n_i),
                .keypad_i    (keypad_p1),
                .kp_sel_n_i  (kp_sel_n_i[1]),
                .joy_sel_n_i (joy_sel_n_i[1]),
                .lines_o     (pad_lines_o[7:4]),
                .fire_o      (pad_fire_o[1])
        );

endmodule

//--- src/joy_keypad_map.sv
//==============================
// joystick to keypad mapper
// optional player swap, reorders each joystick word into a keypad
// vector and merges in the keyboard keys
//==============================

`timescale 1ns/1ps

module joy_keypad_map (
        input  logic [coleco_pad_pkg::JOY_W-1:0] joy0_i,
        input  logic [coleco_pad_pkg::JOY_W-1:0] joy1_i,
        input  logic                             swap_i,
        input  coleco_pad_pkg::keypad_t          kbd_keypad_i,
        output coleco_pad_pkg::keypad_t          keypad_p0_o,
        output coleco_pad_pkg::keypad_t          keypad_p1_o
);

        logic [coleco_pad_pkg::JOY_W-1:0] joy_p0;
        logic [coleco_pad_pkg::JOY_W-1:0] joy_p1;
        coleco_pad_pkg::keypad_t          map_p0;
        coleco_pad_pkg::keypad_t          map_p1;

        //==============================
        // player swap
        //==============================
        assign joy_p0 = swap_i ? joy1_i : joy0_i;
        assign joy_p1 = swap_i ? joy0_i : joy1_i;

        // reorder by the source bit table
        always_comb begin
                for (int k = 0; k < coleco_pad_pkg::KEYPAD_W; k++) begin
                        map_p0[k] = joy_p0[coleco_pad_pkg::joy_src_table[k]];
                        map_p1[k] = joy_p1[coleco_pad_pkg::joy_src_table[k]];
                end
        end

        // keyboard keys count for both players
        assign keypad_p0_o = map_p0 | kbd_keypad_i;
        assign keypad_p1_o = map_p1 | kbd_keypad_i;

endmodule

//--- src/pad_port_encoder.sv
//==============================
// controller port encoder
// one player's port lines and fire line, selected by the keypad
// and joystick strobes, registered toward the console
//==============================

`timescale 1ns/1ps

module pad_port_encoder (
        input  logic                    clk_sys,
        input  logic                    rst_n_i,
        input  coleco_pad_pkg::keypad_t keypad_i,
        input  logic                    kp_sel_n_i,
        input  logic                    joy_sel_n_i,
        output logic [3:0]              lines_o,
        output logic                    fire_o
);

        coleco_pad_pkg::key_code_t kp_code;
        logic [3:0]                kp_lines;
        logic                      kp_fire;
        logic [3:0]                joy_lines;
        logic                      joy_fire;

        //==============================
        // keypad segment
        //==============================
        // scan downward so the lowest set index is the one kept
        always_comb begin
                kp_code = coleco_pad_pkg::KEY_NONE;
                for (int k = coleco_pad_pkg::KP_KEYS - 1; k >= 0; k--) begin
                        if (keypad_i[k]) begin
                                kp_code = coleco_pad_pkg::key_code_table[k];
                        end
                end
        end

        always_comb begin
                kp_lines = 4'b1111;
                kp_fire  = 1'b1;
                if (!kp_sel_n_i) begin
                        kp_lines = kp_code;
                        // fire 2 shows up on the keypad segment
                        kp_fire  = ~keypad_i[coleco_pad_pkg::KP_FIRE2];
                end
        end

        //==============================
        // joystick segment
        //==============================
        always_comb begin
                joy_lines = 4'b1111;
                joy_fire  = 1'b1;
                if (!joy_sel_n_i) begin
                        joy_lines = ~{keypad_i[coleco_pad_pkg::KP_UP],
                                      keypad_i[coleco_pad_pkg::KP_DOWN],
                                      keypad_i[coleco_pad_pkg::KP_LEFT],
                                      keypad_i[coleco_pad_pkg::KP_RIGHT]};
                        joy_fire  = ~keypad_i[coleco_pad_pkg::KP_FIRE1];
                end
        end

        // active low lines, so both segments combine by AND
        always_ff @(posedge clk_sys) begin
                if (!rst_n_i) begin
                        lines_o <= 4'b1111;
                        fire_o  <= 1'b1;
                end else begin
                        lines_o <= kp_lines & joy_lines;
                        fire_o  <= kp_fire & joy_fire;
                end
        end

endmodule

//--- src/ps2_keypad_emu.sv
//==============================
// ps2 keypad emulation
// tracks keyboard make/break events and holds the state of the
// digit, star, shift and minus keys as a keypad vector
//==============================

`timescale 1ns/1ps

module ps2_keypad_emu (
        input  logic                                 clk_sys,
        input  logic                                 rst_n_i,
        input  logic [coleco_pad_pkg::PS2_W-1:0]     ps2_key_i,
        output coleco_pad_pkg::keypad_t              kbd_keypad_o
);

        logic       toggle_q;
        logic       armed_q;
        logic       key_event;
        logic       pressed;
        logic [7:0] scan;

        logic [9:0] digit_q;
        logic       star_q;
        logic       shift_q;
        logic       minus_q;

        assign pressed   = ps2_key_i[9];
        assign scan      = ps2_key_i[7:0];
        // a new event flips bit 10
        assign key_event = armed_q && (toggle_q != ps2_key_i[10]);

        //==============================
        // button state
        //==============================
        always_ff @(posedge clk_sys) begin
                if (!rst_n_i) begin
                        toggle_q <= 1'b0;
                        armed_q  <= 1'b0;
                        digit_q  <= '0;
                        star_q   <= 1'b0;
                        shift_q  <= 1'b0;
                        minus_q  <= 1'b0;
                end else begin
                        // first cycle out of reset only picks up the live level
                        toggle_q <= ps2_key_i[10];
                        armed_q  <= 1'b1;
                        if (key_event) begin
                                case (scan)
                                        coleco_pad_pkg::SC_0, coleco_pad_pkg::SCK_0:
                                                digit_q[0] <= pressed;
                                        coleco_pad_pkg::SC_1, coleco_pad_pkg::SCK_1:
                                                digit_q[1] <= pressed;
                                        coleco_pad_pkg::SC_2, coleco_pad_pkg::SCK_2:
                                                digit_q[2] <= pressed;
                                        coleco_pad_pkg::SC_3, coleco_pad_pkg::SCK_3:
                                                digit_q[3] <= pressed;
                                        coleco_pad_pkg::SC_4, coleco_pad_pkg::SCK_4:
                                                digit_q[4] <= pressed;
                                        coleco_pad_pkg::SC_5, coleco_pad_pkg::SCK_5:
                                                digit_q[5] <= pressed;
                                        coleco_pad_pkg::SC_6, coleco_pad_pkg::SCK_6:
                                                digit_q[6] <= pressed;
                                        coleco_pad_pkg::SC_7, coleco_pad_pkg::SCK_7:
                                                digit_q[7] <= pressed;
                                        coleco_pad_pkg::SC_8, coleco_pad_pkg::SCK_8:
                                                digit_q[8] <= pressed;
                                        coleco_pad_pkg::SC_9, coleco_pad_pkg::SCK_9:
                                                digit_q[9] <= pressed;
                                        coleco_pad_pkg::SC_STAR:
                                                star_q <= pressed;
                                        // either shift key drives one shared state
                                        coleco_pad_pkg::SC_LSHIFT, coleco_pad_pkg::SC_RSHIFT:
                                                shift_q <= pressed;
                                        coleco_pad_pkg::SC_MINUS:
                                                minus_q <= pressed;
                                        default: begin
                                        end
                                endcase
                        end
                end
        end

        //==============================
        // keypad vector
        //==============================
        always_comb begin
                kbd_keypad_o = '0;
                kbd_keypad_o[coleco_pad_pkg::KP_DIGIT0] = digit_q[0];
                kbd_keypad_o[coleco_pad_pkg::KP_DIGIT1] = digit_q[1];
                kbd_keypad_o[coleco_pad_pkg::KP_DIGIT2] = digit_q[2];
                kbd_keypad_o[coleco_pad_pkg::KP_DIGIT3] = digit_q[3];
                kbd_keypad_o[coleco_pad_pkg::KP_DIGIT4] = digit_q[4];
                kbd_keypad_o[coleco_pad_pkg::KP_DIGIT5] = digit_q[5];
                kbd_keypad_o[coleco_pad_pkg::KP_DIGIT6] = digit_q[6];
                kbd_keypad_o[coleco_pad_pkg::KP_DIGIT7] = digit_q[7];
                kbd_keypad_o[coleco_pad_pkg::KP_DIGIT8] = digit_q[8];
                kbd_keypad_o[coleco_pad_pkg::KP_DIGIT9] = digit_q[9];
                // shift+8 and shift+3 as on a US layout
                kbd_keypad_o[coleco_pad_pkg::KP_STAR] = star_q | (shift_q & digit_q[8]);
                kbd_keypad_o[coleco_pad_pkg::KP_HASH] = minus_q | (shift_q & digit_q[3]);
        end

endmodule

//--- testbench/pad_stimulus.txt
// columns: ev key joy0 joy1 swap kp_sel_n joy_sel_n wait exp_lines exp_fire
// ev 1 flips the toggle with key = {pressed, scan}, ev f ends the table
// idle, both strobes high
0 000 00000000 00000000 0 3 3 1 ff 3
// keypad segment, lowest index wins
0 000 00000840 00040000 0 0 3 1 46 3
0 000 00000000 00080020 0 0 3 1 2f 1
0 000 00020180 000020a0 0 0 3 1 93 1
0 000 00000019 00008000 0 0 3 1 cf 3
// joystick segment
0 000 0000001a 00000225 0 3 0 1 a5 2
0 000 00000000 0000001f 0 3 0 1 0f 1
// both segments selected
0 000 00000418 00000061 0 0 0 1 a5 0
0 000 00000000 00001002 0 0 0 1 1f 3
// keypad on player 0, joystick on player 1
0 000 00004010 00000018 0 2 1 1 77 1
// player swap
0 000 00004010 00000018 1 2 1 1 ff 1
0 000 00010000 00000200 1 0 3 1 8e 3
0 000 00010000 00000200 0 0 3 1 e8 3
// keyboard, numeric pad 7 press and release
1 26c 00000000 00000000 0 0 3 2 cc 3
1 06c 00000000 00000000 0 0 3 2 ff 3
// shift held, digit 8 is below star in priority
1 212 00000000 00000000 0 0 3 2 ff 3
1 23e 00000000 00000000 0 0 3 2 88 3
1 03e 00000000 00000000 0 0 3 2 ff 3
1 27a 00000000 00000000 0 0 3 2 66 3
1 07a 00000000 00000000 0 0 3 2 ff 3
1 012 00000000 00000000 0 0 3 2 ff 3
// star and minus keys
1 27c 00000000 00000000 0 0 3 2 aa 3
1 07c 00000000 00000000 0 0 3 2 ff 3
1 27b 00000000 00000000 0 0 3 2 55 3
1 07b 00000000 00000000 0 0 3 2 ff 3
// keyboard merged with joystick
1 21e 00000000 00000000 0 0 3 2 dd 3
0 000 00000000 00000100 0 0 3 1 3d 3
1 01e 00000000 00000100 0 0 3 2 3f 3
// end of table
f 000 00000000 00000000 0 0 0 0 00 0

//--- testbench/tb_coleco_pad.sv
//==============================
// coleco pad testbench
// runs the steps of the stimulus table through the top level
// and checks port lines and fire lines after each step
//==============================

`timescale 1ns/1ps

module tb_coleco_pad;

        localparam int STEP_WORDS   = 10;
        localparam int MAX_STEPS    = 100;
        localparam int RESET_CYCLES = 10;

        logic                             clk_sys = 1'b0;
        logic                             rst_n_i;
        logic [coleco_pad_pkg::PS2_W-1:0] ps2_key_i;
        logic [coleco_pad_pkg::JOY_W-1:0] joy0_i;
        logic [coleco_pad_pkg::JOY_W-1:0] joy1_i;
        logic                             swap_i;
        logic [1:0]                       kp_sel_n_i;
        logic [1:0]                       joy_sel_n_i;
        logic [7:0]                       pad_lines_o;
        logic [1:0]                       pad_fire_o;

        // flat table, STEP_WORDS words per step
        logic [31:0] stim_mem [0:1023];
        logic [15:0] lfsr_state;
        int          check_count = 0;
        int          error_count = 0;
        int          cycle_count = 0;
        int          cycle_limit = 0;

        always #2 clk_sys = ~clk_sys;

        coleco_pad_top u_coleco_pad_top (
                .clk_sys     (clk_sys),
                .rst_n_i     (rst_n_i),
                .ps2_key_i   (ps2_key_i),
                .joy0_i      (joy0_i),
                .joy1_i      (joy1_i),
                .swap_i      (swap_i),
                .kp_sel_n_i  (kp_sel_n_i),
                .joy_sel_n_i (joy_sel_n_i),
                .pad_lines_o (pad_lines_o),
                .pad_fire_o  (pad_fire_o)
        );

        //==============================
        // helpers
        //==============================
        // x^16 + x^14 + x^13 + x^11 + 1
        function automatic logic [15:0] lfsr_next(input logic [15:0] state);
                logic feedback;
                feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
                return {state[14:0], feedback};
        endfunction

        // one lfsr step per bit taken
        task automatic random_upper(output logic [11:0] bits);
                for (int i = 0; i < 12; i++) begin
                        lfsr_state = lfsr_next(lfsr_state);
                        bits[i]    = lfsr_state[0];
                end
        endtask

        function automatic logic [31:0] stim_word(input logic [9:0] base, input logic [3:0] col);
                return stim_mem[base + {6'd0, col}];
        endfunction

        task automatic check_outputs(input logic [7:0] exp_lines, input logic [1:0] exp_fire);
                check_count++;
                assert (pad_lines_o === exp_lines) else begin
                        error_count++;
                        $display("FAIL time=%0t pad_lines_o expected=%h actual=%h",
                                 $time, exp_lines, pad_lines_o);
                end
                assert (pad_fire_o === exp_fire) else begin
                        error_count++;
                        $display("FAIL time=%0t pad_fire_o expected=%b actual=%b",
                                 $time, exp_fire, pad_fire_o);
                end
        endtask

        //==============================
        // timeout
        //==============================
        always @(posedge clk_sys) begin
                cycle_count <= cycle_count + 1;
                if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
                        $display("timeout: run did not finish within %0d cycles", cycle_limit);
                        $display(">>> FAIL");
                        $finish;
                end
        end

        //==============================
        // stimulus and checks
        //==============================
        initial begin
                logic [9:0]  base;
                logic [31:0] key_w;
                logic [31:0] joy0_w;
                logic [31:0] joy1_w;
                logic [31:0] swap_w;
                logic [31:0] kp_w;
                logic [31:0] js_w;
                logic [31:0] lines_w;
                logic [31:0] fire_w;
                logic [11:0] rnd0;
                logic [11:0] rnd1;
                logic        toggle;
                int          step_total;
                int          wait_total;

                // joystick bits set during reset must not reach the ports
                rst_n_i     = 1'b0;
                // toggle high with a pressed keypad 7 across reset, a stale level and no event
                ps2_key_i   = {1'b1, 1'b1, 1'b0, coleco_pad_pkg::SCK_7};
                joy0_i      = 32'h000F_FFFF;
                joy1_i      = 32'h000F_FFFF;
                swap_i      = 1'b0;
                kp_sel_n_i  = 2'b00;
                joy_sel_n_i = 2'b00;
                lfsr_state  = 16'd18633;
                toggle      = 1'b1;

                $readmemh("testbench/pad_stimulus.txt", stim_mem);

                // walk the table up to the end marker
                step_total = 0;
                wait_total = 0;
                base       = '0;
                while (step_total < MAX_STEPS && stim_word(base, 4'd0) != 32'hF) begin
                        wait_total += int'(stim_word(base, 4'd7));
                        step_total++;
                        base = base + 10'(STEP_WORDS);
                end
                cycle_limit = 3 * (wait_total + RESET_CYCLES);
                if (step_total == 0) begin
                        error_count++;
                        $display("stimulus table is missing or holds no steps");
                end

                // release on the last reset edge, DUT still samples it low
                for (int c = 0; c < RESET_CYCLES; c++) begin
                        @(posedge clk_sys);
                        if (c == RESET_CYCLES - 1) begin
                                rst_n_i     <= 1'b1;
                                joy0_i      <= '0;
                                joy1_i      <= '0;
                                kp_sel_n_i  <= 2'b11;
                                joy_sel_n_i <= 2'b11;
                        end
                        @(negedge clk_sys);
                        check_outputs(8'hFF, 2'b11);
                end

                base = '0;
                for (int s = 0; s < step_total; s++) begin
                        key_w   = stim_word(base, 4'd1);
                        joy0_w  = stim_word(base, 4'd2);
                        joy1_w  = stim_word(base, 4'd3);
                        swap_w  = stim_word(base, 4'd4);
                        kp_w    = stim_word(base, 4'd5);
                        js_w    = stim_word(base, 4'd6);
                        lines_w = stim_word(base, 4'd8);
                        fire_w  = stim_word(base, 4'd9);
                        random_upper(rnd0);
                        random_upper(rnd1);

                        @(posedge clk_sys);
                        // keyboard event, flip bit 10
                        if (stim_word(base, 4'd0) == 32'h1) begin
                                toggle = ~toggle;
                                ps2_key_i <= {toggle, key_w[9:0]};
                        end
                        joy0_i      <= {rnd0, joy0_w[19:0]};
                        joy1_i      <= {rnd1, joy1_w[19:0]};
                        swap_i      <= swap_w[0];
                        kp_sel_n_i  <= kp_w[1:0];
                        joy_sel_n_i <= js_w[1:0];

                        repeat (stim_word(base, 4'd7)) @(posedge clk_sys);
                        @(negedge clk_sys);
                        check_outputs(lines_w[7:0], fire_w[1:0]);
                        base = base + 10'(STEP_WORDS);
                end

                $display("checks=%0d errors=%0d", check_count, error_count);
                if (error_count == 0) begin
                        $display(">>> PASS");
                end else begin
                        $display(">>> FAIL");
                end
                $finish;
        end

endmodule
